// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary -j 0
LINT_FLAGS ?= --lint-only -Wall
TOP        := rv_core_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
PASS_TEXT  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
verilog/rv_core_pkg.sv
verilog/control_if.sv
verilog/control_decoder.sv
verilog/alu_decoder.sv
verilog/alu.sv
verilog/register_file.sv
verilog/immediate_generator.sv
verilog/rv_core.sv
verification/rv_core_tb.sv

// File: verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int clk_period    = 40;
    localparam int reset_cycles  = 8;
    localparam int seq_cycles    = 20;
    localparam int arith_rounds  = 3;
    localparam int arith_cycles  = 48;
    localparam int upper_cycles  = 12;
    localparam int mem_cycles    = 16;
    localparam int branch_cycles = 16;
    localparam int zero_cycles   = 8;
    // One reset per test and per arithmetic round
    localparam int total_cycles = (5 + arith_rounds) * reset_cycles + seq_cycles
        + arith_rounds * arith_cycles + upper_cycles + mem_cycles + branch_cycles
        + zero_cycles;

    logic                  CLK;
    logic                  RESET_N;
    logic [xlen-1:0]       q_rom;
    logic [addr_width-1:0] addr_rom;
    logic [addr_width-1:0] addr_ram;
    logic [xlen-1:0]       q_ram;
    logic [xlen-1:0]       q_w;
    logic                  enable_w;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] pc_trace [$];  // addr_rom after each executed cycle
    int          pc_idx;        // Next free ROM word while building a program
    int          errors;
    int          checks;

    // Index k of the R-type table also selects the rule in isa_result
    string      op_names [10] = '{"add", "sub", "sll", "slt", "sltu",
                                  "xor", "srl", "sra", "or", "and"};
    logic [2:0] funct3_tab [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                    3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic       bit30_tab [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                   1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    rv_core dut (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .q_rom    (q_rom),
        .addr_rom (addr_rom),
        .addr_ram (addr_ram),
        .q_ram    (q_ram),
        .q_w      (q_w),
        .enable_w (enable_w)
    );

    // Word-addressed memory models with combinational reads
    assign q_rom = rom[addr_rom[addr_width-1:2]];
    assign q_ram = ram[addr_ram[addr_width-1:2]];

    always #(clk_period / 2) CLK = ~CLK;

    function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, op_rtype};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] funct3,
                                          input logic [4:0] rd);
        return {imm, rs1, funct3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};  // sw only
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(input opcode_e op, input logic [19:0] imm,
                                          input logic [4:0] rd);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {8'hc3, idx, ~idx, 8'h3c};
    endfunction

    // RV32I result rules per operation
    function automatic logic [31:0] isa_result(input int k, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a << sh;
            3: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            4: return {31'b0, a < b};
            5: return a ^ b;
            6: return a >> sh;
            7: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        rom[8'(pc_idx)] = word;
        pc_idx++;
    endtask

    task automatic store_word(input logic [4:0] rs2, input int word_idx);
        emit(enc_s(12'(4 * word_idx), rs2, 5'd0));
    endtask

    // lui plus addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(enc_u(op_lui, upper[31:12], rd));
        emit(enc_i(op_itype, value[11:0], rd, 3'b000, rd));
    endtask

    task automatic start_program();
        for (int i = 0; i < 256; i++) begin
            rom[8'(i)] = enc_i(op_itype, {4'h0, 8'(i)}, 5'd0, 3'b000, 5'd0);  // addi x0 nop
            ram[8'(i)] = fill_word(8'(i));
        end
        pc_idx = 1;  // Word 0 stays a nop
    endtask

    task automatic apply_reset(input string name);
        RESET_N = 1'b0;
        repeat (reset_cycles) begin
            @(negedge CLK);
            check({name, " addr_rom in reset"}, 32'd0, 32'(addr_rom));
        end
        RESET_N = 1'b1;
        pc_trace.delete();
    endtask

    // Runs n instructions and does the RAM write at the rising edge
    task automatic run_cycles(input string name, input int n);
        logic [31:0] word;
        logic        write_pending;
        logic [7:0]  write_idx;
        logic [31:0] write_data;
        repeat (n) begin
            word = rom[addr_rom[addr_width-1:2]];
            check({name, " enable_w"}, {31'b0, word[6:0] == op_store}, {31'b0, enable_w});
            write_pending = enable_w;
            write_idx     = addr_ram[addr_width-1:2];
            write_data    = q_w;
            @(posedge CLK);
            if (write_pending) begin
                ram[write_idx] = write_data;
            end
            @(negedge CLK);
            pc_trace.push_back(32'(addr_rom));
        end
    endtask

    task automatic test_sequencing();
        start_program();
        apply_reset("sequencing");
        run_cycles("sequencing", seq_cycles);
        for (int k = 0; k < pc_trace.size(); k++) begin
            check("sequencing addr_rom", 32'(4 * (k + 1)), pc_trace[k]);
        end
    endtask

    task automatic test_arith(input int round);
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [11:0] imm_used [10];
        string       name;
        name = $sformatf("arith round %0d", round);
        a    = $urandom();
        b    = $urandom();
        imm  = 12'($urandom());
        start_program();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(enc_r(bit30_tab[k] ? 7'b0100000 : 7'b0, 5'd2, 5'd1, funct3_tab[k], 5'd3));
            store_word(5'd3, 64 + k);
        end
        for (int k = 0; k < 10; k++) begin
            if (k != 1) begin  // No subi
                imm_used[k] = imm;
                if (funct3_tab[k] == 3'd1 || funct3_tab[k] == 3'd5) begin
                    imm_used[k] = {bit30_tab[k] ? 7'b0100000 : 7'b0, imm[4:0]};
                end
                emit(enc_i(op_itype, imm_used[k], 5'd1, funct3_tab[k], 5'd3));
                store_word(5'd3, 80 + k);
            end
        end
        apply_reset(name);
        run_cycles(name, arith_cycles);
        for (int k = 0; k < 10; k++) begin
            check({name, " ", op_names[k]}, isa_result(k, a, b), ram[8'(64 + k)]);
            if (k != 1) begin
                check({name, " ", op_names[k], "i"},
                      isa_result(k, a, {{20{imm_used[k][11]}}, imm_used[k]}),
                      ram[8'(80 + k)]);
            end
        end
    endtask

    task automatic test_upper_immediates();
        logic [19:0] u_lui;
        logic [19:0] u_auipc;
        logic [31:0] auipc_pc;
        u_lui   = 20'($urandom());
        u_auipc = 20'($urandom());
        u_lui[7:3] = 5'd7;  // rs1 field of the lui names x7
        start_program();
        emit(enc_i(op_itype, 12'h5a5, 5'd0, 3'b000, 5'd7));  // Nonzero x7 that lui must ignore
        emit(enc_u(op_lui, u_lui, 5'd5));
        store_word(5'd5, 120);
        auipc_pc = 32'(4 * pc_idx);
        emit(enc_u(op_auipc, u_auipc, 5'd6));
        store_word(5'd6, 121);
        apply_reset("upper");
        run_cycles("upper", upper_cycles);
        check("upper lui", {u_lui, 12'b0}, ram[8'd120]);
        check("upper auipc", auipc_pc + {u_auipc, 12'b0}, ram[8'd121]);
    endtask

    task automatic test_loads_stores();
        logic [31:0] data [4];
        start_program();
        for (int i = 0; i < 4; i++) begin
            data[i]            = $urandom();
            ram[8'(100 + i)] = data[i];
        end
        emit(enc_i(op_load, 12'd400, 5'd0, 3'b010, 5'd1));
        emit(enc_i(op_load, 12'd404, 5'd0, 3'b010, 5'd2));
        emit(enc_r(7'b0, 5'd2, 5'd1, 3'b000, 5'd3));
        store_word(5'd3, 104);
        emit(enc_i(op_load, 12'd408, 5'd0, 3'b010, 5'd4));
        emit(enc_i(op_load, 12'd412, 5'd0, 3'b010, 5'd5));
        emit(enc_r(7'b0, 5'd5, 5'd4, 3'b000, 5'd6));
        store_word(5'd6, 105);
        emit(enc_i(op_load, 12'd416, 5'd0, 3'b010, 5'd7));  // Reads back the first sum
        store_word(5'd7, 106);
        apply_reset("load store");
        run_cycles("load store", mem_cycles);
        check("load store sum0", data[0] + data[1], ram[8'd104]);
        check("load store sum1", data[2] + data[3], ram[8'd105]);
        check("load store reload", data[0] + data[1], ram[8'd106]);
        check("load store source", data[2], ram[8'd102]);
    endtask

    task automatic test_branches();
        logic [31:0] taken_pc;
        logic [31:0] exp_pc;
        start_program();
        emit(enc_i(op_itype, 12'd5, 5'd0, 3'b000, 5'd1));
        emit(enc_i(op_itype, 12'd5, 5'd0, 3'b000, 5'd2));
        emit(enc_i(op_itype, 12'd9, 5'd0, 3'b000, 5'd3));
        emit(enc_i(op_itype, 12'h011, 5'd0, 3'b000, 5'd4));  // Marker value
        taken_pc = 32'(4 * pc_idx);
        emit(enc_b(13'd8, 5'd2, 5'd1));  // Equal operands skip the next store
        store_word(5'd4, 130);
        emit(enc_b(13'd8, 5'd3, 5'd1));  // Unequal operands fall through
        store_word(5'd4, 131);
        apply_reset("branch");
        run_cycles("branch", branch_cycles);
        exp_pc = 32'd0;
        for (int k = 0; k < pc_trace.size(); k++) begin
            exp_pc = (exp_pc == taken_pc) ? exp_pc + 32'd8 : exp_pc + 32'd4;
            check("branch addr_rom", exp_pc, pc_trace[k]);
        end
        check("branch skipped marker", fill_word(8'd130), ram[8'd130]);
        check("branch fall-through marker", 32'h11, ram[8'd131]);
    endtask

    task automatic test_zero_register();
        start_program();
        emit(enc_i(op_itype, 12'h07b, 5'd0, 3'b000, 5'd0));
        store_word(5'd0, 140);
        emit(enc_i(op_itype, 12'd77, 5'd0, 3'b000, 5'd1));
        emit(enc_r(7'b0, 5'd1, 5'd1, 3'b000, 5'd0));
        store_word(5'd0, 141);
        store_word(5'd1, 142);
        apply_reset("x0");
        run_cycles("x0", zero_cycles);
        check("x0 after addi", 32'd0, ram[8'd140]);
        check("x0 after add", 32'd0, ram[8'd141]);
        check("x0 source reg", 32'd77, ram[8'd142]);
    endtask

    initial begin
        CLK     = 1'b0;
        RESET_N = 1'b0;
        errors  = 0;
        checks  = 0;
        pc_idx  = 1;
        void'($urandom(52));
        test_sequencing();
        for (int r = 0; r < arith_rounds; r++) begin
            test_arith(r);
        end
        test_upper_immediates();
        test_loads_stores();
        test_branches();
        test_zero_register();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Twice the time all tests need
    initial begin
        #(total_cycles * clk_period * 2);
        $display("ERROR: watchdog timeout, the tests did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [rv_core_pkg::xlen-1:0] a,
    input  logic [rv_core_pkg::xlen-1:0] b,
    input  rv_core_pkg::alu_op_e         op,
    output logic [rv_core_pkg::xlen-1:0] result,
    output logic                         zero
);
    import rv_core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // RV32 shifts use 5 bits

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt: begin
                result = '0;
                result[0] = ($signed(a) < $signed(b));
            end
            alu_sltu: begin
                result = '0;
                result[0] = (a < b);
            end
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $unsigned($signed(a) >>> shamt);
            default:  result = '0;
        endcase
    end

    // Branch compare flag
    assign zero = (result == '0);

endmodule

// File: verilog/alu_decoder.sv
`timescale 1ns/10ps

module alu_decoder (
    control_if.alu               ctrl,
    input  logic [2:0]           funct3,
    input  logic                 bit30,
    output rv_core_pkg::alu_op_e alu_op
);
    import rv_core_pkg::*;

    logic is_reg;

    assign is_reg = (ctrl.alu_class == class_reg);

    always_comb begin
        alu_op = alu_add;
        case (ctrl.alu_class)
            class_add: alu_op = alu_add;
            class_sub: alu_op = alu_sub;
            default: begin
                case (funct3)
                    3'b000:  alu_op = (is_reg && bit30) ? alu_sub : alu_add;  // addi has no sub
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = bit30 ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
        endcase
    end

endmodule

// File: verilog/control_decoder.sv
`timescale 1ns/10ps

module control_decoder (
    input rv_core_pkg::opcode_e instr_opcode,
    control_if.decoder          ctrl
);
    import rv_core_pkg::*;

    always_comb begin
        // Unknown opcodes fall out as a nop
        ctrl.branch        = 1'b0;
        ctrl.mem_to_reg    = 1'b0;
        ctrl.mem_write     = 1'b0;
        ctrl.alu_src       = 1'b0;
        ctrl.reg_write     = 1'b0;
        ctrl.alu_class     = class_add;
        ctrl.operand_a_sel = sel_pc;

        case (instr_opcode)
            op_rtype: begin
                ctrl.reg_write     = 1'b1;
                ctrl.alu_class     = class_reg;
                ctrl.operand_a_sel = sel_rs1;
            end
            op_itype: begin
                ctrl.alu_src       = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.alu_class     = class_imm;
                ctrl.operand_a_sel = sel_rs1;
            end
            op_load: begin
                ctrl.alu_src       = 1'b1;  // rs1 + offset
                ctrl.mem_to_reg    = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.operand_a_sel = sel_rs1;
            end
            op_store: begin
                ctrl.alu_src       = 1'b1;
                ctrl.mem_write     = 1'b1;
                ctrl.operand_a_sel = sel_rs1;
            end
            op_branch: begin
                ctrl.branch        = 1'b1;  // Taken on zero difference
                ctrl.alu_class     = class_sub;
                ctrl.operand_a_sel = sel_rs1;
            end
            op_lui: begin
                ctrl.alu_src       = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.operand_a_sel = sel_zero;  // 0 + imm
            end
            op_auipc: begin
                ctrl.alu_src       = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.operand_a_sel = sel_pc;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/control_if.sv
`timescale 1ns/10ps

interface control_if;
    import rv_core_pkg::*;

    logic           branch;
    logic           mem_to_reg;
    logic           mem_write;
    logic           alu_src;        // Immediate as second operand
    logic           reg_write;
    alu_class_e     alu_class;
    operand_a_sel_e operand_a_sel;

    modport decoder (
        output branch, mem_to_reg, mem_write, alu_src, reg_write, alu_class, operand_a_sel
    );

    // Core view of the bundle, ALU class goes to the ALU decoder only
    modport datapath (
        input branch, mem_to_reg, mem_write, alu_src, reg_write, operand_a_sel
    );

    modport alu (input alu_class);

endinterface

// File: verilog/immediate_generator.sv
`timescale 1ns/10ps

module immediate_generator (
    input  logic [rv_core_pkg::xlen-1:0] instr,
    output logic [rv_core_pkg::xlen-1:0] imm
);
    import rv_core_pkg::*;

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(instr[6:0]);
    assign sign   = instr[31];

    // Field slicing is fixed to the 32-bit encoding
    always_comb begin
        case (opcode)
            op_store:
                imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            op_branch:
                imm = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            op_lui, op_auipc:
                imm = {instr[31:12], 12'b0};  // Upper 20 bits
            default:
                imm = {{(xlen-12){sign}}, instr[31:20]};  // I format, also loads
        endcase
    end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                         CLK,
    input  logic                         RESET_N,
    input  logic [4:0]                   rs1_addr,
    input  logic [4:0]                   rs2_addr,
    input  logic [4:0]                   rd_addr,
    input  logic [rv_core_pkg::xlen-1:0] rd_data,
    input  logic                         reg_write,
    output logic [rv_core_pkg::xlen-1:0] rs1_data,
    output logic [rv_core_pkg::xlen-1:0] rs2_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;  // x0 stays zero
        end
    end

    // Asynchronous read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic                               CLK,
    input  logic                               RESET_N,
    input  logic [rv_core_pkg::xlen-1:0]       q_rom,
    output logic [rv_core_pkg::addr_width-1:0] addr_rom,
    output logic [rv_core_pkg::addr_width-1:0] addr_ram,
    input  logic [rv_core_pkg::xlen-1:0]       q_ram,
    output logic [rv_core_pkg::xlen-1:0]       q_w,
    output logic                               enable_w
);
    import rv_core_pkg::*;

    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] pc_plus4;
    logic [addr_width-1:0] branch_target;
    logic [addr_width-1:0] next_pc;
    logic                  take_branch;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_data;
    logic            alu_zero;
    alu_op_e         alu_op;

    control_if ctrl_bus ();

    control_decoder u_control_decoder (
        .instr_opcode (opcode_e'(q_rom[6:0])),
        .ctrl         (ctrl_bus)
    );

    alu_decoder u_alu_decoder (
        .ctrl   (ctrl_bus),
        .funct3 (q_rom[14:12]),
        .bit30  (q_rom[30]),
        .alu_op (alu_op)
    );

    register_file u_register_file (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .rs1_addr  (q_rom[19:15]),
        .rs2_addr  (q_rom[24:20]),
        .rd_addr   (q_rom[11:7]),
        .rd_data   (wb_data),
        .reg_write (ctrl_bus.reg_write),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    immediate_generator u_immediate_generator (
        .instr (q_rom),
        .imm   (imm)
    );

    // Operand A: PC for auipc, zero for lui, rs1 otherwise
    always_comb begin
        case (ctrl_bus.operand_a_sel)
            sel_pc:   operand_a = {{(xlen-addr_width){1'b0}}, pc};
            sel_zero: operand_a = '0;
            default:  operand_a = rs1_data;
        endcase
    end

    assign operand_b = ctrl_bus.alu_src ? imm : rs2_data;

    alu u_alu (
        .a      (operand_a),
        .b      (operand_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign wb_data = ctrl_bus.mem_to_reg ? q_ram : alu_result;  // Load or ALU

    // Next PC selection
    assign pc_plus4      = pc + addr_width'(4);
    assign branch_target = pc + imm[addr_width-1:0];
    assign take_branch   = ctrl_bus.branch & alu_zero;
    assign next_pc       = take_branch ? branch_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign addr_rom = pc;
    assign addr_ram = alu_result[addr_width-1:0];
    assign q_w      = rs2_data;
    assign enable_w = ctrl_bus.mem_write;  // Only store cycles write

endmodule

// File: verilog/rv_core_pkg.sv
package rv_core_pkg;

    // Data and instruction word width
    localparam int xlen = 32;

    // Byte address width seen by both memories
    localparam int addr_width = 10;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    // Hint from the main decoder to the ALU decoder
    typedef enum logic [1:0] {
        class_add = 2'b00,  // Address and upper-immediate arithmetic
        class_sub = 2'b01,  // beq compare
        class_reg = 2'b10,  // R-type, funct3 and bit 30 decoded
        class_imm = 2'b11   // I-type, bit 30 only for shifts
    } alu_class_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // First ALU operand source
    typedef enum logic [1:0] {
        sel_pc   = 2'd0,  // auipc
        sel_zero = 2'd1,  // lui
        sel_rs1  = 2'd2
    } operand_a_sel_e;

endpackage
